/* ma_dp_pkg.sv */
// --------------------------------------------------------------------------
// Shared widths, types and select encodings of the MA arithmetic datapath
// Fixed at 64-bit words with one parity bit per 32-bit lane
// Lane parity is odd: ones in the lane plus its parity bit is always odd
// --------------------------------------------------------------------------
`default_nettype none

package ma_dp_pkg;

        // Word and lane geometry
        localparam int WORD_W    = 64;
        localparam int LANE_W    = 32;
        localparam int NUM_LANES = WORD_W / LANE_W;

        typedef logic [WORD_W-1:0]    word_t;
        // Bit 1 covers 63..32, bit 0 covers 31..0
        typedef logic [NUM_LANES-1:0] par_t;

        // Scratch memory word, parity sits above the data
        typedef struct packed {
                par_t  par;
                word_t data;
        } mem_word_t;

        // Operand 1 source toward the multiplier, code 3 is unused
        typedef enum logic [1:0] {
                OP1_RD_Q   = 2'd0,
                OP1_RD_DIR = 2'd1,
                OP1_NP     = 2'd2
        } oprnd1_sel_e;

        // Result register source
        typedef enum logic [1:0] {
                RES_MUL  = 2'd0,
                RES_ZERO = 2'd1,
                RES_OP2  = 2'd2,
                RES_DIFF = 2'd3
        } res_sel_e;

        // Odd parity per lane, zero data gives all ones
        function automatic par_t lane_par(input word_t w);
                par_t p;
                for (int i = 0; i < NUM_LANES; i++) begin
                        p[i] = ~(^w[i*LANE_W +: LANE_W]);
                end
                return p;
        endfunction

endpackage

`default_nettype wire

/* ma_rd_path.sv */
// --------------------------------------------------------------------------
// Scratch memory read selection and read parity check
// The check register loads every cycle, perr refers to last cycle's word
// --------------------------------------------------------------------------
`default_nettype none

module ma_rd_path (
        input  wire                  rclk,
        input  wire                  rst,
        input  wire ma_dp_pkg::mem_word_t mem_eve_data,
        input  wire ma_dp_pkg::mem_word_t mem_odd_data,
        input  wire                  rd_odd,
        output ma_dp_pkg::word_t     rd_data,
        output ma_dp_pkg::word_t     rd_data_q,
        output ma_dp_pkg::par_t      rd_par_q,
        output logic                 perr
);

        ma_dp_pkg::mem_word_t rd_word;
        ma_dp_pkg::par_t      par_gen;
        ma_dp_pkg::par_t      par_mis;

        // ------------------------------------------------------------------------
        // Bank select
        // ------------------------------------------------------------------------

        // Odd bank when rd_odd, even bank otherwise
        assign rd_word = rd_odd ? mem_odd_data : mem_eve_data;

        // Direct word fans out to all datapath blocks
        assign rd_data = rd_word.data;

        // ------------------------------------------------------------------------
        // Check register
        // ------------------------------------------------------------------------

        // Reset value 0 with parity 11 is a clean word
        always_ff @(posedge rclk) begin
                if (rst) begin
                        rd_data_q <= '0;
                        rd_par_q  <= '1;
                end else begin
                        rd_data_q <= rd_word.data;
                        rd_par_q  <= rd_word.par;
                end
        end

        // Regenerate lane parity from the registered data
        assign par_gen = ma_dp_pkg::lane_par(rd_data_q);

        // Per lane mismatch, upper and lower
        assign par_mis = rd_par_q ^ par_gen;

        // Any lane in error flags the word
        assign perr = |par_mis;

endmodule

`default_nettype wire

/* ma_oprnd_regs.sv */
// --------------------------------------------------------------------------
// Multiplier operand registers: operand 2, N-prime and operand 1 select
// op1_data is combinational, op2_data is registered under op2_wen
// Select code 3 of op1_sel drives zero
// --------------------------------------------------------------------------
`default_nettype none

module ma_oprnd_regs (
        input  wire                         rclk,
        input  wire                         rst,
        input  wire ma_dp_pkg::word_t       rd_data,
        input  wire ma_dp_pkg::word_t       rd_data_q,
        input  wire ma_dp_pkg::word_t       mul_data,
        input  wire                         op2_wen,
        input  wire                         op2_bypass,
        input  wire ma_dp_pkg::oprnd1_sel_e op1_sel,
        input  wire                         np_wen,
        input  wire ma_dp_pkg::word_t       st_data,
        output ma_dp_pkg::word_t            op1_data,
        output ma_dp_pkg::word_t            op2_data
);

        ma_dp_pkg::word_t op2_d;
        ma_dp_pkg::word_t np_q;

        // ------------------------------------------------------------------------
        // Operand 2 (A, M or accumulator)
        // ------------------------------------------------------------------------

        // Bypass feeds the multiplier result straight back
        assign op2_d = op2_bypass ? mul_data : rd_data;

        always_ff @(posedge rclk) begin
                if (rst) begin
                        op2_data <= '0;
                end else if (op2_wen) begin
                        op2_data <= op2_d;
                end
        end

        // ------------------------------------------------------------------------
        // N-prime, written from store data
        // ------------------------------------------------------------------------

        always_ff @(posedge rclk) begin
                if (rst) begin
                        np_q <= '0;
                end else if (np_wen) begin
                        np_q <= st_data;
                end
        end

        // Operand 1 (B, N or N-prime)
        always_comb begin
                case (op1_sel)
                        ma_dp_pkg::OP1_RD_Q:   op1_data = rd_data_q;
                        ma_dp_pkg::OP1_RD_DIR: op1_data = rd_data;
                        ma_dp_pkg::OP1_NP:     op1_data = np_q;
                        // spare code
                        default:               op1_data = '0;
                endcase
        end

endmodule

`default_nettype wire

/* ma_mod_reduce.sv */
// --------------------------------------------------------------------------
// Modulus register, op2 minus N subtractor, equality compare, result reg
// Flags are combinational from registered op2, registered N and cin
// res_q updates one cycle after res_wen
// --------------------------------------------------------------------------
`default_nettype none

module ma_mod_reduce (
        input  wire                      rclk,
        input  wire                      rst,
        input  wire ma_dp_pkg::word_t    rd_data,
        input  wire ma_dp_pkg::word_t    op2_data,
        input  wire ma_dp_pkg::word_t    mul_data,
        input  wire                      mod_wen,
        input  wire                      cin,
        input  wire ma_dp_pkg::res_sel_e res_sel,
        input  wire                      res_wen,
        output ma_dp_pkg::word_t         res_q,
        output logic                     cout,
        output logic                     m_lt_n,
        output logic                     m_eq_n,
        output ma_dp_pkg::word_t         store_data
);

        ma_dp_pkg::word_t            mod_q;
        ma_dp_pkg::word_t            mod_n_b;
        logic [ma_dp_pkg::WORD_W:0]  sum;
        ma_dp_pkg::word_t            diff;
        ma_dp_pkg::word_t            res_d;

        // ------------------------------------------------------------------------
        // Modulus N
        // ------------------------------------------------------------------------

        always_ff @(posedge rclk) begin
                if (rst) begin
                        mod_q <= '0;
                end else if (mod_wen) begin
                        mod_q <= rd_data;
                end
        end

        // Modulus is also the store-back word
        assign store_data = mod_q;

        // ------------------------------------------------------------------------
        // Subtract: op2 + ~N + cin
        // ------------------------------------------------------------------------

        assign mod_n_b = ~mod_q;

        // One extra bit keeps the carry
        assign sum = {1'b0, op2_data} + {1'b0, mod_n_b} + {{ma_dp_pkg::WORD_W{1'b0}}, cin};

        assign diff = sum[ma_dp_pkg::WORD_W-1:0];

        // No carry means op2 < N (with cin set)
        assign cout   = sum[ma_dp_pkg::WORD_W];
        assign m_lt_n = ~cout;

        // Full width compare
        assign m_eq_n = (op2_data == mod_q);

        // ------------------------------------------------------------------------
        // Result select and register
        // ------------------------------------------------------------------------

        always_comb begin
                case (res_sel)
                        ma_dp_pkg::RES_MUL:  res_d = mul_data;
                        // clear to zero
                        ma_dp_pkg::RES_ZERO: res_d = '0;
                        ma_dp_pkg::RES_OP2:  res_d = op2_data;
                        ma_dp_pkg::RES_DIFF: res_d = diff;
                        default:             res_d = '0;
                endcase
        end

        always_ff @(posedge rclk) begin
                if (rst) begin
                        res_q <= '0;
                end else if (res_wen) begin
                        res_q <= res_d;
                end
        end

endmodule

`default_nettype wire

/* ma_exp_shift.sv */
// --------------------------------------------------------------------------
// Exponent register, loaded from the read word or shifted left by one
// e_shift only acts together with e_wen
// --------------------------------------------------------------------------
`default_nettype none

module ma_exp_shift (
        input  wire                   rclk,
        input  wire                   rst,
        input  wire ma_dp_pkg::word_t rd_data,
        input  wire                   e_wen,
        input  wire                   e_shift,
        output logic                  e_eq_one
);

        ma_dp_pkg::word_t e_q;
        ma_dp_pkg::word_t e_d;

        // Shift brings in zero at bit 0
        assign e_d = e_shift ? {e_q[ma_dp_pkg::WORD_W-2:0], 1'b0} : rd_data;

        always_ff @(posedge rclk) begin
                if (rst) begin
                        e_q <= '0;
                end else if (e_wen) begin
                        e_q <= e_d;
                end
        end

        // Current exponent bit seen by the sequencer
        assign e_eq_one = e_q[ma_dp_pkg::WORD_W-1];

endmodule

`default_nettype wire

/* ma_wb_path.sv */
// --------------------------------------------------------------------------
// Write-back words for the even and odd banks, with generated lane parity
// Outputs are registered every cycle from res_q and the delayed read word
// force_perr inverts all parity bits of both words in the same cycle
// --------------------------------------------------------------------------
`default_nettype none

module ma_wb_path (
        input  wire                   rclk,
        input  wire                   rst,
        input  wire ma_dp_pkg::word_t res_q,
        input  wire ma_dp_pkg::word_t rd_data,
        input  wire                   wb_swap,
        input  wire                   force_perr,
        output ma_dp_pkg::mem_word_t  eve_data,
        output ma_dp_pkg::mem_word_t  odd_data
);

        ma_dp_pkg::word_t mem_q;
        ma_dp_pkg::word_t eve_word;
        ma_dp_pkg::word_t odd_word;
        ma_dp_pkg::par_t  par_flip;
        ma_dp_pkg::par_t  eve_par;
        ma_dp_pkg::par_t  odd_par;

        // ------------------------------------------------------------------------
        // Upper half, read word delayed one cycle
        // ------------------------------------------------------------------------

        always_ff @(posedge rclk) begin
                if (rst) begin
                        mem_q <= '0;
                end else begin
                        mem_q <= rd_data;
                end
        end

        // ------------------------------------------------------------------------
        // Bank steering and parity generation
        // ------------------------------------------------------------------------

        // Normal: even gets the read word, odd gets the result
        assign eve_word = wb_swap ? res_q : mem_q;
        assign odd_word = wb_swap ? mem_q : res_q;

        // Error injection on every lane
        assign par_flip = {ma_dp_pkg::NUM_LANES{force_perr}};

        assign eve_par = ma_dp_pkg::lane_par(eve_word) ^ par_flip;
        assign odd_par = ma_dp_pkg::lane_par(odd_word) ^ par_flip;

        // Output registers, reset to a clean zero word
        always_ff @(posedge rclk) begin
                if (rst) begin
                        eve_data.data <= '0;
                        eve_data.par  <= '1;
                        odd_data.data <= '0;
                        odd_data.par  <= '1;
                end else begin
                        eve_data.data <= eve_word;
                        eve_data.par  <= eve_par;
                        odd_data.data <= odd_word;
                        odd_data.par  <= odd_par;
                end
        end

endmodule

`default_nettype wire

/* ma_dp.sv */
// --------------------------------------------------------------------------
// MA arithmetic datapath top, steered cycle by cycle by an outside sequencer
// No handshakes and no back-pressure, every strobe acts in its own cycle
// --------------------------------------------------------------------------
`default_nettype none

module ma_dp (
        input  wire                         rclk,
        input  wire                         rst,
        // Scratch memory read
        input  wire ma_dp_pkg::mem_word_t   mem_eve_data,
        input  wire ma_dp_pkg::mem_word_t   mem_odd_data,
        input  wire                         rd_odd,
        // Multiplier and operand control
        input  wire ma_dp_pkg::word_t       mul_data,
        input  wire                         op2_wen,
        input  wire                         op2_bypass,
        input  wire ma_dp_pkg::oprnd1_sel_e op1_sel,
        input  wire                         np_wen,
        input  wire ma_dp_pkg::word_t       st_data,
        // Reduction control
        input  wire                         mod_wen,
        input  wire                         cin,
        input  wire ma_dp_pkg::res_sel_e    res_sel,
        input  wire                         res_wen,
        // Exponent control
        input  wire                         e_wen,
        input  wire                         e_shift,
        // Write-back control
        input  wire                         wb_swap,
        input  wire                         force_perr,
        output wire ma_dp_pkg::word_t       op1_data,
        output wire ma_dp_pkg::word_t       op2_data,
        output wire                         m_lt_n,
        output wire                         m_eq_n,
        output wire                         cout,
        output wire ma_dp_pkg::word_t       store_data,
        output wire                         e_eq_one,
        output wire                         perr,
        output wire ma_dp_pkg::mem_word_t   eve_data,
        output wire ma_dp_pkg::mem_word_t   odd_data
);

        wire ma_dp_pkg::word_t rd_data;
        wire ma_dp_pkg::word_t rd_data_q;
        wire ma_dp_pkg::word_t res_q;

        // Read path, stored parity stays local to the check
        ma_rd_path rd_path_inst (
                .rclk         (rclk),
                .rst          (rst),
                .mem_eve_data (mem_eve_data),
                .mem_odd_data (mem_odd_data),
                .rd_odd       (rd_odd),
                .rd_data      (rd_data),
                .rd_data_q    (rd_data_q),
                .rd_par_q     (),
                .perr         (perr)
        );

        ma_oprnd_regs oprnd_regs_inst (
                .rclk       (rclk),
                .rst        (rst),
                .rd_data    (rd_data),
                .rd_data_q  (rd_data_q),
                .mul_data   (mul_data),
                .op2_wen    (op2_wen),
                .op2_bypass (op2_bypass),
                .op1_sel    (op1_sel),
                .np_wen     (np_wen),
                .st_data    (st_data),
                .op1_data   (op1_data),
                .op2_data   (op2_data)
        );

        ma_mod_reduce mod_reduce_inst (
                .rclk       (rclk),
                .rst        (rst),
                .rd_data    (rd_data),
                .op2_data   (op2_data),
                .mul_data   (mul_data),
                .mod_wen    (mod_wen),
                .cin        (cin),
                .res_sel    (res_sel),
                .res_wen    (res_wen),
                .res_q      (res_q),
                .cout       (cout),
                .m_lt_n     (m_lt_n),
                .m_eq_n     (m_eq_n),
                .store_data (store_data)
        );

        ma_exp_shift exp_shift_inst (
                .rclk     (rclk),
                .rst      (rst),
                .rd_data  (rd_data),
                .e_wen    (e_wen),
                .e_shift  (e_shift),
                .e_eq_one (e_eq_one)
        );

        ma_wb_path wb_path_inst (
                .rclk       (rclk),
                .rst        (rst),
                .res_q      (res_q),
                .rd_data    (rd_data),
                .wb_swap    (wb_swap),
                .force_perr (force_perr),
                .eve_data   (eve_data),
                .odd_data   (odd_data)
        );

endmodule

`default_nettype wire

/* tb_ma_dp_model.svh */
// --------------------------------------------------------------------------
// Cycle model of every datapath register, included inside the tb module
// Needs the DUT input variables declared before the include point
// update_model is called right at the rising edge, before inputs change
// --------------------------------------------------------------------------
`ifndef TB_MA_DP_MODEL_SVH
`define TB_MA_DP_MODEL_SVH

        // Mirrored registers
        ma_dp_pkg::word_t     mdl_rd_q;
        ma_dp_pkg::par_t      mdl_par_q;
        ma_dp_pkg::word_t     mdl_op2;
        ma_dp_pkg::word_t     mdl_np;
        ma_dp_pkg::word_t     mdl_mod;
        ma_dp_pkg::word_t     mdl_res;
        ma_dp_pkg::word_t     mdl_exp;
        ma_dp_pkg::word_t     mdl_mem_q;
        ma_dp_pkg::mem_word_t mdl_eve;
        ma_dp_pkg::mem_word_t mdl_odd;

        // Odd parity per 32-bit lane, ones counted bit by bit
        function automatic ma_dp_pkg::par_t odd_parity(input ma_dp_pkg::word_t w);
                ma_dp_pkg::par_t p;
                int              ones;
                for (int l = 0; l < 2; l++) begin
                        ones = 0;
                        for (int b = 0; b < 32; b++) begin
                                ones += w[l*32 + b];
                        end
                        // Even count needs a set parity bit
                        p[l] = (ones % 2 == 0);
                end
                return p;
        endfunction

        // Word on the read bus in the current cycle
        function automatic ma_dp_pkg::word_t read_word();
                return rd_odd ? mem_odd_data.data : mem_eve_data.data;
        endfunction

        // Carry out whenever op2 exceeds N, or equals N with cin set
        function automatic logic reduce_carry();
                return (mdl_op2 > mdl_mod) || ((mdl_op2 == mdl_mod) && cin);
        endfunction

        // Difference op2 minus N minus one plus cin, wrapped to 64 bits
        function automatic ma_dp_pkg::word_t reduce_diff();
                return mdl_op2 - mdl_mod - {63'h0, ~cin};
        endfunction

        function automatic ma_dp_pkg::word_t result_next();
                case (res_sel)
                        ma_dp_pkg::RES_MUL:  return mul_data;
                        ma_dp_pkg::RES_ZERO: return '0;
                        ma_dp_pkg::RES_OP2:  return mdl_op2;
                        default:             return reduce_diff();
                endcase
        endfunction

        task automatic update_model();
                ma_dp_pkg::word_t res_n;
                ma_dp_pkg::word_t eve_w;
                ma_dp_pkg::word_t odd_w;
                if (rst) begin
                        mdl_rd_q  = '0;
                        mdl_par_q = 2'b11;
                        mdl_op2   = '0;
                        mdl_np    = '0;
                        mdl_mod   = '0;
                        mdl_res   = '0;
                        mdl_exp   = '0;
                        mdl_mem_q = '0;
                        mdl_eve   = {2'b11, 64'h0};
                        mdl_odd   = {2'b11, 64'h0};
                end else begin
                        // Next values from the old register contents first
                        res_n   = result_next();
                        eve_w   = wb_swap ? mdl_res : mdl_mem_q;
                        odd_w   = wb_swap ? mdl_mem_q : mdl_res;
                        mdl_eve = {odd_parity(eve_w) ^ {2{force_perr}}, eve_w};
                        mdl_odd = {odd_parity(odd_w) ^ {2{force_perr}}, odd_w};
                        if (res_wen) begin
                                mdl_res = res_n;
                        end
                        if (e_wen) begin
                                mdl_exp = e_shift ? {mdl_exp[62:0], 1'b0} : read_word();
                        end
                        if (op2_wen) begin
                                mdl_op2 = op2_bypass ? mul_data : read_word();
                        end
                        if (np_wen) begin
                                mdl_np = st_data;
                        end
                        if (mod_wen) begin
                                mdl_mod = read_word();
                        end
                        mdl_mem_q = read_word();
                        mdl_rd_q  = read_word();
                        mdl_par_q = rd_odd ? mem_odd_data.par : mem_eve_data.par;
                end
        endtask

`endif

/* tb_ma_dp.sv */
// --------------------------------------------------------------------------
// Random testbench for the MA datapath, checked against a cycle model
// Inputs change 1 ns after the rising edge, outputs are sampled 1 ns later
// op1_sel code 3 is never driven
// --------------------------------------------------------------------------
`default_nettype none

module tb_ma_dp;
        timeunit 1ns;
        timeprecision 100ps;

        localparam int RAND_CYCLES = 2000;
        localparam int EXP_ROUNDS  = 8;

        // DUT inputs
        logic                        rclk;
        logic                        rst;
        ma_dp_pkg::mem_word_t        mem_eve_data;
        ma_dp_pkg::mem_word_t        mem_odd_data;
        logic                        rd_odd;
        ma_dp_pkg::word_t            mul_data;
        logic                        op2_wen;
        logic                        op2_bypass;
        ma_dp_pkg::oprnd1_sel_e      op1_sel;
        logic                        np_wen;
        ma_dp_pkg::word_t            st_data;
        logic                        mod_wen;
        logic                        cin;
        ma_dp_pkg::res_sel_e         res_sel;
        logic                        res_wen;
        logic                        e_wen;
        logic                        e_shift;
        logic                        wb_swap;
        logic                        force_perr;
        // DUT outputs
        ma_dp_pkg::word_t            op1_data;
        ma_dp_pkg::word_t            op2_data;
        ma_dp_pkg::word_t            store_data;
        logic                        m_lt_n;
        logic                        m_eq_n;
        logic                        cout;
        logic                        e_eq_one;
        logic                        perr;
        ma_dp_pkg::mem_word_t        eve_data;
        ma_dp_pkg::mem_word_t        odd_data;

        integer                      seed;
        int                          errors;
        int                          checks;
        ma_dp_pkg::word_t            loaded_e;
        int                          shifts;

        `include "tb_ma_dp_model.svh"

        ma_dp ma_dp_inst (.*);

        // 4 ns clock
        always #2 rclk = ~rclk;

        task automatic compare_val(input string name, input logic [65:0] got,
                                   input logic [65:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("Fail %s at %0t: got %h, expected %h", name, $time, got, exp);
                end
        endtask

        function automatic ma_dp_pkg::word_t random_word();
                return {$random(seed), $random(seed)};
        endfunction

        // Good parity most of the time, one lane bit flipped otherwise
        function automatic ma_dp_pkg::mem_word_t random_mem_word();
                ma_dp_pkg::word_t d;
                ma_dp_pkg::par_t  p;
                int               lane;
                d = random_word();
                p = odd_parity(d);
                if (($random(seed) & 3) == 0) begin
                        lane    = $random(seed) & 1;
                        p[lane] = ~p[lane];
                end
                return {p, d};
        endfunction

        task automatic drive_random();
                int pick;
                mem_eve_data = random_mem_word();
                mem_odd_data = random_mem_word();
                rd_odd       = ($random(seed) & 1) == 1;
                mul_data     = random_word();
                st_data      = random_word();
                op2_wen      = ($random(seed) & 1) == 1;
                op2_bypass   = ($random(seed) & 1) == 1;
                np_wen       = ($random(seed) & 3) == 0;
                mod_wen      = ($random(seed) & 3) == 0;
                cin          = ($random(seed) & 1) == 1;
                res_wen      = ($random(seed) & 1) == 1;
                e_wen        = ($random(seed) & 1) == 1;
                e_shift      = ($random(seed) & 1) == 1;
                wb_swap      = ($random(seed) & 1) == 1;
                force_perr   = ($random(seed) & 3) == 0;
                pick         = ($random(seed) & 32'h7fff_ffff) % 3;
                op1_sel      = ma_dp_pkg::oprnd1_sel_e'(pick[1:0]);
                pick         = $random(seed) & 3;
                res_sel      = ma_dp_pkg::res_sel_e'(pick[1:0]);
                // Same word into operand 2 and N, equal next cycle
                if (($random(seed) & 7) == 0) begin
                        op2_wen    = 1'b1;
                        op2_bypass = 1'b0;
                        mod_wen    = 1'b1;
                end
        endtask

        task automatic advance_clock();
                @(posedge rclk);
                update_model();
                #1;
        endtask

        task automatic check_outputs();
                ma_dp_pkg::word_t op1_exp;
                logic             carry;
                case (op1_sel)
                        ma_dp_pkg::OP1_RD_Q:   op1_exp = mdl_rd_q;
                        ma_dp_pkg::OP1_RD_DIR: op1_exp = read_word();
                        ma_dp_pkg::OP1_NP:     op1_exp = mdl_np;
                        default:               op1_exp = '0;
                endcase
                carry = reduce_carry();
                compare_val("op1_data", op1_data, op1_exp);
                compare_val("op2_data", op2_data, mdl_op2);
                compare_val("store_data", store_data, mdl_mod);
                compare_val("cout", cout, carry);
                compare_val("m_lt_n", m_lt_n, !carry);
                compare_val("m_eq_n", m_eq_n, mdl_op2 == mdl_mod);
                compare_val("e_eq_one", e_eq_one, mdl_exp[63]);
                compare_val("perr", perr, mdl_par_q != odd_parity(mdl_rd_q));
                compare_val("eve_data", eve_data, mdl_eve);
                compare_val("odd_data", odd_data, mdl_odd);
        endtask

        initial begin
                seed         = 47558;
                errors       = 0;
                checks       = 0;
                rclk         = 1'b0;
                rst          = 1'b1;
                mem_eve_data = {2'b11, 64'h0};
                mem_odd_data = {2'b11, 64'h0};
                rd_odd       = 1'b0;
                mul_data     = '0;
                st_data      = '0;
                op2_wen      = 1'b0;
                op2_bypass   = 1'b0;
                op1_sel      = ma_dp_pkg::OP1_RD_Q;
                np_wen       = 1'b0;
                mod_wen      = 1'b0;
                cin          = 1'b0;
                res_sel      = ma_dp_pkg::RES_MUL;
                res_wen      = 1'b0;
                e_wen        = 1'b0;
                e_shift      = 1'b0;
                wb_swap      = 1'b0;
                force_perr   = 1'b0;

                // Reset held for 10 cycles
                for (int i = 0; i < 10; i++) begin
                        advance_clock();
                end
                rst = 1'b0;
                #1;
                compare_val("perr", perr, 1'b0);
                compare_val("eve_data", eve_data, {2'b11, 64'h0});
                compare_val("odd_data", odd_data, {2'b11, 64'h0});
                check_outputs();

                // ------------------------------------------------------------------
                // Random strobes and selects
                // ------------------------------------------------------------------
                for (int n = 0; n < RAND_CYCLES; n++) begin
                        advance_clock();
                        drive_random();
                        #1;
                        check_outputs();
                end

                // ------------------------------------------------------------------
                // Exponent load, then k left shifts
                // ------------------------------------------------------------------
                for (int r = 0; r < EXP_ROUNDS; r++) begin
                        advance_clock();
                        drive_random();
                        e_wen    = 1'b1;
                        e_shift  = 1'b0;
                        loaded_e = read_word();
                        shifts   = 1 + (($random(seed) & 32'h7fff_ffff) % 63);
                        #1;
                        check_outputs();
                        // After j shifts the top bit is loaded bit 63 - j
                        for (int j = 0; j <= shifts; j++) begin
                                advance_clock();
                                drive_random();
                                e_wen   = (j < shifts);
                                e_shift = 1'b1;
                                #1;
                                check_outputs();
                                compare_val("e_eq_one", e_eq_one, loaded_e[63 - j]);
                        end
                end

                $display("Checks run %0d, errors %0d", checks, errors);
                if (errors == 0) begin
                        $display("Testbench passed");
                end else begin
                        $display("Testbench failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* ma_dp.f */
+incdir+.
ma_dp_pkg.sv
ma_rd_path.sv
ma_oprnd_regs.sv
ma_mod_reduce.sv
ma_exp_shift.sv
ma_wb_path.sv
ma_dp.sv
tb_ma_dp.sv

/* Bender.yml */
package:
  name: ma_dp

sources:
  - files:
      - ma_dp_pkg.sv
      - ma_rd_path.sv
      - ma_oprnd_regs.sv
      - ma_mod_reduce.sv
      - ma_exp_shift.sv
      - ma_wb_path.sv
      - ma_dp.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ma_dp.sv
